//--- audio_cfg.svh
// ====================
// audio playback config
// widths and reset levels shared by the audio channel
// ====================

`ifndef AUDIO_CFG_SVH
`define AUDIO_CFG_SVH

`define AUDIO_ADDR_W      16        // memory word address bits
`define AUDIO_WORD_W      16        // memory data word bits
`define AUDIO_DAC_W       8         // DAC level bits

`define AUDIO_LEVEL_RST   8'h00     // level driven out of reset
`define AUDIO_SILENCE     8'h00     // signed sample used on underrun

`endif

//--- audio_pkg.sv
// ====================
// audio package
// address, word and byte types plus the channel
// register and mixer level structs
// ====================

`include "audio_cfg.svh"

package audio_pkg;

    typedef logic [`AUDIO_ADDR_W-1:0] addr_t;     // memory word address
    typedef logic [`AUDIO_WORD_W-1:0] word_t;     // memory data word
    typedef logic [`AUDIO_DAC_W-1:0]  byte_t;     // sample or level byte

    // channel registers in 62 bits
    typedef struct packed {
        logic [15:0] vol;       // [15:9] left, [7:1] right
        logic [14:0] period;    // sample period minus one
        addr_t       start;     // first word of the sample
        logic [14:0] len;       // length in words minus one
    } chan_regs_t;

    // unsigned DAC levels
    typedef struct packed {
        byte_t l;
        byte_t r;
    } mix_levels_t;

endpackage

//--- audio_period_timer.sv
// ====================
// audio period timer
// strobes once every period + 1 cycles
// ====================

`timescale 1ns/1ps

module audio_period_timer (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        enable_i,
    input  logic [14:0] period_i,
    output logic        tick_o
);

    logic [15:0] cnt;           // bit 15 is the underflow flag
    logic [15:0] reload;

    // the underflow cycle counts as one, so load period - 1
    assign reload = {1'b0, period_i} - 16'd1;

    assign tick_o = cnt[15] && enable_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cnt <= '0;          // first tick on the following cycle
        end else if (!enable_i) begin
            cnt <= reload;      // stay armed but quiet
        end else if (cnt[15]) begin
            cnt <= reload;
        end else begin
            cnt <= cnt - 16'd1;
        end
    end

endmodule

//--- audio_fetch_fsm.sv
// ====================
// audio fetch engine
// fetches sample words on DMA slots, steps the address
// and wraps back to start after len + 1 words
// ====================

`timescale 1ns/1ps

module audio_fetch_fsm (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   enable_i,
    input  audio_pkg::chan_regs_t  regs_i,
    input  logic                   dma_slot_i,
    input  logic                   buf_room_i,
    input  audio_pkg::word_t       mem_word_i,
    output logic                   fetch_o,
    output audio_pkg::addr_t       fetch_addr_o,
    output logic                   wr_en_o,
    output audio_pkg::word_t       wr_word_o
);

    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        RESTART = 2'd1,
        RUN     = 2'd2
    } fetch_state_t;

    fetch_state_t     state;
    audio_pkg::addr_t addr;         // next address to fetch
    logic [14:0]      remain;       // words left before wrap
    logic             fetch;

    // only fetch with room in the buffer, skip the slot otherwise
    assign fetch = (state == RUN) && enable_i && dma_slot_i && buf_room_i;

    assign fetch_o      = fetch;
    assign fetch_addr_o = addr;
    assign wr_en_o      = fetch;
    assign wr_word_o    = mem_word_i;   // memory answers in the same cycle

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state  <= IDLE;
            addr   <= '0;
            remain <= '0;
        end else if (!enable_i) begin
            state  <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    state <= RESTART;
                end
                RESTART: begin
                    addr   <= regs_i.start;
                    remain <= regs_i.len;
                    state  <= RUN;
                end
                RUN: begin
                    if (fetch) begin
                        if (remain == '0) begin
                            addr   <= regs_i.start;    // wrap to the top
                            remain <= regs_i.len;
                        end else begin
                            addr   <= addr + 1'b1;
                            remain <= remain - 1'b1;
                        end
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

//--- audio_sample_buffer.sv
// ====================
// audio sample buffer
// two-word queue, hands out bytes high first on each tick
// and silence when empty
// ====================

`timescale 1ns/1ps

`include "audio_cfg.svh"

module audio_sample_buffer (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              enable_i,
    input  logic              wr_en_i,
    input  audio_pkg::word_t  wr_word_i,
    input  logic              tick_i,
    output logic              buf_room_o,
    output audio_pkg::byte_t  sample_o
);

    audio_pkg::word_t word0;        // oldest word
    audio_pkg::word_t word1;
    logic             vld0;
    logic             vld1;
    logic             half;         // low byte is next
    logic             pop;

    // after the low byte goes out the word is done
    assign pop        = tick_i && vld0 && half;
    assign buf_room_o = !(vld0 && vld1);

    always_ff @(posedge clk) begin
        if (reset_i || !enable_i) begin
            vld0     <= 1'b0;
            vld1     <= 1'b0;
            half     <= 1'b0;
            sample_o <= `AUDIO_SILENCE;
        end else begin
            if (tick_i) begin
                if (vld0) begin
                    sample_o <= half ? word0[7:0] : word0[15:8];
                    half     <= !half;
                end else begin
                    sample_o <= `AUDIO_SILENCE;     // underrun
                end
            end

            // drop the spent word, then place any new one in the first free slot
            if (pop) begin
                word0 <= wr_en_i && !vld1 ? wr_word_i : word1;
                vld0  <= vld1 || wr_en_i;
                vld1  <= wr_en_i && vld1;
                if (wr_en_i && vld1) begin
                    word1 <= wr_word_i;
                end
            end else if (wr_en_i) begin
                if (!vld0) begin
                    word0 <= wr_word_i;
                    vld0  <= 1'b1;
                end else begin
                    word1 <= wr_word_i;
                    vld1  <= 1'b1;
                end
            end
        end
    end

endmodule

//--- audio_volume_mix.sv
// ====================
// audio volume mixer
// two-phase scaling of the sample by left and right volume,
// converted to unsigned DAC levels
// ====================

`timescale 1ns/1ps

`include "audio_cfg.svh"

module audio_volume_mix (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    enable_i,
    input  audio_pkg::byte_t        sample_i,
    input  logic [15:0]             vol_i,
    output audio_pkg::mix_levels_t  level_o
);

    logic               phase;
    logic signed [7:0]  smp_q;      // latched sample
    logic signed [7:0]  vol_l_q;    // zero-extended volumes
    logic signed [7:0]  vol_r_q;
    logic signed [15:0] prod_l;
    logic signed [15:0] prod_r;

    assign prod_l = smp_q * vol_l_q;
    assign prod_r = smp_q * vol_r_q;

    // phase 0 latches the sample and both volumes
    always_ff @(posedge clk) begin
        if (phase == 1'b0) begin
            smp_q   <= $signed(sample_i);
            vol_l_q <= $signed({1'b0, vol_i[15:9]});
            vol_r_q <= $signed({1'b0, vol_i[7:1]});
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            phase   <= 1'b0;
            level_o <= {`AUDIO_LEVEL_RST, `AUDIO_LEVEL_RST};
        end else begin
            phase <= !phase;
            if (!enable_i) begin
                level_o.l <= vol_i[15:8];   // raw volume bytes straight out
                level_o.r <= vol_i[7:0];
            end else if (phase == 1'b1) begin
                level_o.l <= {~prod_l[13], prod_l[12:6]};   // offset to unsigned
                level_o.r <= {~prod_r[13], prod_r[12:6]};
            end
        end
    end

endmodule

//--- audio_dac.sv
// ====================
// audio PDM DAC
// first-order sigma-delta, pulse density equals the level
// ====================

`timescale 1ns/1ps

module audio_dac #(
    parameter int WIDTH = 8
) (
    input  logic             clk,
    input  logic             reset_i,
    input  logic [WIDTH-1:0] value_i,
    output logic             pulse_o
);

    logic [WIDTH:0] acc;            // top bit holds the carry

    assign pulse_o = acc[WIDTH];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            acc <= '0;
        end else begin
            acc <= {1'b0, acc[WIDTH-1:0]} + {1'b0, value_i};
        end
    end

endmodule

//--- audio_mixer.sv
// ====================
// audio playback channel
// period timer, fetch engine, sample buffer, volume mixer
// and a PDM DAC per side
// ====================

`timescale 1ns/1ps

`include "audio_cfg.svh"

module audio_mixer (
    input  logic                    clk,
    input  logic                    reset_i,
    input  audio_pkg::chan_regs_t   regs_i,
    input  logic                    enable_i,
    input  logic                    dma_slot_i,
    input  audio_pkg::word_t        mem_word_i,
    output logic                    fetch_o,
    output audio_pkg::addr_t        fetch_addr_o,
    output logic                    sample_tick_o,
    output audio_pkg::mix_levels_t  level_o,
    output logic                    pdm_l_o,
    output logic                    pdm_r_o
);

    logic                   tick;
    logic                   buf_room;
    logic                   wr_en;
    audio_pkg::word_t       wr_word;
    audio_pkg::byte_t       sample;
    audio_pkg::mix_levels_t level;

    assign sample_tick_o = tick;
    assign level_o       = level;

    audio_period_timer timer (
        .clk      (clk),
        .reset_i  (reset_i),
        .enable_i (enable_i),
        .period_i (regs_i.period),
        .tick_o   (tick)
    );

    audio_fetch_fsm fetch (
        .clk          (clk),
        .reset_i      (reset_i),
        .enable_i     (enable_i),
        .regs_i       (regs_i),
        .dma_slot_i   (dma_slot_i),
        .buf_room_i   (buf_room),
        .mem_word_i   (mem_word_i),
        .fetch_o      (fetch_o),
        .fetch_addr_o (fetch_addr_o),
        .wr_en_o      (wr_en),
        .wr_word_o    (wr_word)
    );

    audio_sample_buffer sbuf (
        .clk        (clk),
        .reset_i    (reset_i),
        .enable_i   (enable_i),
        .wr_en_i    (wr_en),
        .wr_word_i  (wr_word),
        .tick_i     (tick),
        .buf_room_o (buf_room),
        .sample_o   (sample)
    );

    audio_volume_mix mix (
        .clk      (clk),
        .reset_i  (reset_i),
        .enable_i (enable_i),
        .sample_i (sample),
        .vol_i    (regs_i.vol),
        .level_o  (level)
    );

    audio_dac #(.WIDTH(`AUDIO_DAC_W)) dac_l (
        .clk     (clk),
        .reset_i (reset_i),
        .value_i (level.l),
        .pulse_o (pdm_l_o)
    );

    audio_dac #(.WIDTH(`AUDIO_DAC_W)) dac_r (
        .clk     (clk),
        .reset_i (reset_i),
        .value_i (level.r),
        .pulse_o (pdm_r_o)
    );

endmodule

//--- audio_checker.sv
// ====================
// audio channel checker
// models fetch order, tick spacing, buffer and mixer levels
// and PDM density from the top-level ports
// ====================

`timescale 1ns/1ps

module audio_checker (
    input  logic                    clk,
    input  logic                    reset_i,
    input  audio_pkg::chan_regs_t   regs_i,
    input  logic                    enable_i,
    input  logic                    fetch_i,
    input  audio_pkg::addr_t        fetch_addr_i,
    input  audio_pkg::word_t        mem_word_i,
    input  logic                    tick_i,
    input  audio_pkg::mix_levels_t  level_i,
    input  logic                    pdm_l_i,
    input  logic                    pdm_r_i,
    input  logic                    done_i,
    output int                      errors_o
);

    audio_pkg::word_t       words_q[$];     // fetched words not yet played
    logic                   half;           // low byte is next
    audio_pkg::byte_t       sample;         // byte the mixer should be playing
    logic                   starved;        // sample came from an underrun
    audio_pkg::addr_t       exp_addr;
    int                     since_tick = 0;
    logic                   tick_seen = 1'b0;
    logic                   prev_rst = 1'b1;
    logic                   prev_en = 1'b0;
    logic [15:0]            prev_vol;
    audio_pkg::mix_levels_t prev_level;
    audio_pkg::mix_levels_t win_level;      // level held over the PDM window
    int                     win_cnt = 0;
    int                     win_l;
    int                     win_r;
    int                     err_cnt = 0;
    int                     n_fetch = 0;
    int                     n_tick = 0;
    int                     n_level = 0;
    int                     n_silent = 0;
    int                     n_pass = 0;
    int                     n_pdm = 0;
    logic                   reported = 1'b0;

    assign errors_o = err_cnt;

    task automatic report_mismatch(input string msg);
        err_cnt = err_cnt + 1;
        $display("ERR %0t: %s", $time, msg);
    endtask

    task automatic report_missing(input string msg);
        err_cnt = err_cnt + 1;
        $display("%s", msg);
    endtask

    // signed sample times unsigned volume with bit 13 inverted above bits 12..6
    function automatic audio_pkg::byte_t scaled_level(audio_pkg::byte_t smp, logic [6:0] vol);
        int          prod;
        logic [31:0] bits;
        prod = $signed(smp) * int'(vol);
        bits = prod;
        return {~bits[13], bits[12:6]};
    endfunction

    function automatic audio_pkg::mix_levels_t scaled_levels(audio_pkg::byte_t smp,
                                                             logic [15:0] vol);
        audio_pkg::mix_levels_t lv;
        lv.l = scaled_level(smp, vol[15:9]);
        lv.r = scaled_level(smp, vol[7:1]);
        return lv;
    endfunction

    always @(posedge clk) begin : model
        int                     held;
        audio_pkg::mix_levels_t exp_lv;
        audio_pkg::addr_t       last_addr;
        held      = words_q.size();
        last_addr = regs_i.start + regs_i.len;     // last word before the wrap
        if (!reset_i && fetch_i && !enable_i) begin
            report_mismatch("fetch_o high while the channel is disabled");
        end
        if (reset_i || !enable_i) begin
            words_q.delete();               // buffer flush and fetch restart
            half      = 1'b0;
            sample    = 8'h00;
            starved   = 1'b0;
            tick_seen = 1'b0;
            exp_addr  = regs_i.start;
        end else begin
            since_tick = since_tick + 1;
            if (tick_i) begin
                exp_lv  = scaled_levels(sample, regs_i.vol);
                n_level = n_level + 1;
                if (starved) begin
                    n_silent = n_silent + 1;
                end
                if (level_i !== exp_lv) begin
                    report_mismatch($sformatf("level %h, expected %h (sample %h)",
                                              level_i, exp_lv, sample));
                end
                if (tick_seen) begin
                    n_tick = n_tick + 1;
                    if (since_tick != int'(regs_i.period) + 1) begin
                        report_mismatch($sformatf("tick spacing %0d, expected %0d",
                                                  since_tick, regs_i.period + 1));
                    end
                end
                tick_seen  = 1'b1;
                since_tick = 0;
                if (held == 0) begin
                    sample  = 8'h00;        // underrun plays silence
                    starved = 1'b1;
                end else begin
                    sample  = half ? words_q[0][7:0] : words_q[0][15:8];
                    starved = 1'b0;
                    if (half) begin
                        void'(words_q.pop_front());
                    end
                    half = !half;
                end
            end
            if (fetch_i) begin
                n_fetch = n_fetch + 1;
                if (held >= 2) begin
                    report_mismatch("fetch_o high while the buffer holds two words");
                end
                if (fetch_addr_i !== exp_addr) begin
                    report_mismatch($sformatf("fetch address %h, expected %h",
                                              fetch_addr_i, exp_addr));
                end
                if (exp_addr == last_addr) begin
                    exp_addr = regs_i.start;
                end else begin
                    exp_addr = exp_addr + 1'b1;
                end
                words_q.push_back(mem_word_i);
            end
        end

        // the level seen now was written from last cycle's enable and volume
        if (!reset_i && !prev_rst && !prev_en) begin
            n_pass = n_pass + 1;
            if (level_i !== prev_vol) begin
                report_mismatch($sformatf("pass-through level %h, expected %h",
                                          level_i, prev_vol));
            end
        end

        // each pulse is the carry from adding last cycle's level
        if (reset_i || prev_rst || enable_i) begin
            win_cnt = 0;
        end else begin
            if (win_cnt == 0 || prev_level !== win_level) begin
                win_level = prev_level;
                win_cnt   = 0;
                win_l     = 0;
                win_r     = 0;
            end
            win_cnt = win_cnt + 1;
            win_l   = win_l + pdm_l_i;
            win_r   = win_r + pdm_r_i;
            if (win_cnt == 256) begin
                n_pdm = n_pdm + 1;
                if (win_l != win_level.l || win_r != win_level.r) begin
                    report_mismatch($sformatf("pdm pulses %0d/%0d, expected %0d/%0d",
                                              win_l, win_r, win_level.l, win_level.r));
                end
                win_cnt = 0;
            end
        end

        prev_rst   = reset_i;
        prev_en    = enable_i;
        prev_vol   = regs_i.vol;
        prev_level = level_i;

        if (done_i && !reported) begin
            reported = 1'b1;
            if (n_fetch == 0)  report_missing("no fetch address was checked");
            if (n_tick == 0)   report_missing("no tick spacing was checked");
            if (n_silent == 0) report_missing("no underrun silence level was checked");
            if (n_pass == 0)   report_missing("no pass-through level was checked");
            if (n_pdm == 0)    report_missing("no pdm window was checked");
            $display("fetch %0d tick %0d level %0d silence %0d pass %0d pdm %0d errors %0d",
                     n_fetch, n_tick, n_level, n_silent, n_pass, n_pdm, err_cnt);
        end
    end

endmodule

//--- tb_audio_mixer.sv
// ====================
// audio channel testbench
// random register rounds, memory model, DMA strobes
// and a watchdog around the checker
// ====================

`timescale 1ns/1ps

module tb_audio_mixer;

    localparam int CLK_PERIOD    = 40;
    localparam int RESET_CYCLES  = 8;
    localparam int ROUNDS        = 6;
    localparam int DIS_CYCLES    = 300;     // pass-through and one PDM window
    localparam int RUN_CYCLES    = 700;
    localparam int STARVE_CYCLES = 240;     // no DMA so the buffer runs dry
    localparam int TAIL_CYCLES   = 10;
    localparam int TOTAL_CYCLES  = RESET_CYCLES + TAIL_CYCLES
                                   + ROUNDS * (DIS_CYCLES + RUN_CYCLES + STARVE_CYCLES + 2);
    localparam int WATCHDOG_CYCLES = TOTAL_CYCLES + TOTAL_CYCLES / 10;

    logic                   clk = 1'b0;
    logic                   reset;
    logic                   enable;
    logic                   dma_slot;
    logic                   done;
    audio_pkg::chan_regs_t  regs;
    audio_pkg::word_t       mem_word;
    audio_pkg::word_t       mem_base;       // random part of the memory image
    logic                   fetch;
    audio_pkg::addr_t       fetch_addr;
    logic                   sample_tick;
    audio_pkg::mix_levels_t level;
    logic                   pdm_l;
    logic                   pdm_r;
    int                     errors;
    integer                 seed = 32'hc078_4b39;

    always #(CLK_PERIOD / 2) clk = ~clk;

    // every address bit feeds the word
    function automatic audio_pkg::word_t mem_pattern(audio_pkg::addr_t addr,
                                                     audio_pkg::word_t base);
        return (addr * 16'h9e37) ^ {addr[6:0], addr[15:7]} ^ base;
    endfunction

    assign mem_word = mem_pattern(fetch_addr, mem_base);   // answers in the same cycle

    audio_mixer dut (
        .clk           (clk),
        .reset_i       (reset),
        .regs_i        (regs),
        .enable_i      (enable),
        .dma_slot_i    (dma_slot),
        .mem_word_i    (mem_word),
        .fetch_o       (fetch),
        .fetch_addr_o  (fetch_addr),
        .sample_tick_o (sample_tick),
        .level_o       (level),
        .pdm_l_o       (pdm_l),
        .pdm_r_o       (pdm_r)
    );

    audio_checker chk (
        .clk          (clk),
        .reset_i      (reset),
        .regs_i       (regs),
        .enable_i     (enable),
        .fetch_i      (fetch),
        .fetch_addr_i (fetch_addr),
        .mem_word_i   (mem_word),
        .tick_i       (sample_tick),
        .level_i      (level),
        .pdm_l_i      (pdm_l),
        .pdm_r_i      (pdm_r),
        .done_i       (done),
        .errors_o     (errors)
    );

    // disable the channel and load a fresh set of registers
    task automatic load_round();
        audio_pkg::chan_regs_t r;
        r.vol    = 16'($random(seed));
        r.period = 15'd8 + 15'($unsigned($random(seed)) % 24);
        r.start  = 16'($random(seed));
        r.len    = 15'd2 + 15'($unsigned($random(seed)) % 5);
        @(posedge clk);
        enable <= 1'b0;
        regs   <= r;
    endtask

    task automatic run_cycles(input int n, input bit dma_on);
        int i;
        for (i = 0; i < n; i++) begin
            @(posedge clk);
            dma_slot <= dma_on && (($random(seed) & 3) == 0);   // about one slot in four
        end
    endtask

    initial begin
        int round;
        reset    = 1'b1;
        enable   = 1'b0;
        dma_slot = 1'b0;
        done     = 1'b0;
        regs     = '0;
        mem_base = 16'($random(seed));
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        for (round = 0; round < ROUNDS; round++) begin
            load_round();
            run_cycles(DIS_CYCLES, 1'b1);
            @(posedge clk);
            enable <= 1'b1;
            run_cycles(RUN_CYCLES, 1'b1);
            run_cycles(STARVE_CYCLES, 1'b0);
        end
        @(posedge clk);
        enable <= 1'b0;
        done   <= 1'b1;
        @(posedge clk);
        @(negedge clk);             // checker has printed its counts
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("run timed out after %0d cycles", WATCHDOG_CYCLES);
        $display("sim failed");
        $finish;
    end

endmodule

//--- all.f
+incdir+.
audio_pkg.sv
audio_period_timer.sv
audio_fetch_fsm.sv
audio_sample_buffer.sv
audio_volume_mix.sv
audio_dac.sv
audio_mixer.sv
audio_checker.sv
tb_audio_mixer.sv

//--- Bender.yml
package:
  name: audio_mixer

export_include_dirs:
  - .

sources:
  - audio_pkg.sv
  - audio_period_timer.sv
  - audio_fetch_fsm.sv
  - audio_sample_buffer.sv
  - audio_volume_mix.sv
  - audio_dac.sv
  - audio_mixer.sv
  - target: test
    files:
      - audio_checker.sv
      - tb_audio_mixer.sv
